// File: Makefile
SRCS := $(wildcard design/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_wguard: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_wguard -f files.f

run: obj_dir/Vtb_wguard
	@out="$$(./obj_dir/Vtb_wguard 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir

// File: design/wguard_chan_gate.sv
// ****************************
// Channel gate for AW, W and B
// Bypass, AW back-pressure and
// fault isolation
// ****************************
`timescale 1ns/1ps

module wguard_chan_gate import wguard_pkg::*; (
  input  logic    guard_ena_i,
  input  logic    fault_active_i,
  input  logic    aw_block_i,
  input  wr_req_t mst_req_i,
  output wr_rsp_t mst_rsp_o,
  output wr_req_t slv_req_o,
  input  wr_rsp_t slv_rsp_i,
  output logic    aw_fire_o,
  output logic    w_fire_o,
  output logic    wlast_fire_o,
  output logic    b_fire_o
);

  logic track;

  assign track = guard_ena_i & ~fault_active_i;

  always_comb begin
    slv_req_o = mst_req_i;
    mst_rsp_o = slv_rsp_i;
    if (guard_ena_i) begin
      if (fault_active_i) begin
        // Cut the subordinate off and let the manager drain
        slv_req_o.aw_valid = 1'b0;
        slv_req_o.w_valid  = 1'b0;
        slv_req_o.b_ready  = 1'b1;
        mst_rsp_o.aw_ready = 1'b1;
        mst_rsp_o.w_ready  = 1'b1;
        // Each dropped burst end gets an SLVERR
        mst_rsp_o.b_valid  = mst_req_i.w_valid & mst_req_i.w.last;
        mst_rsp_o.b        = '{id: '0, resp: resp_slverr};
      end else if (aw_block_i) begin
        slv_req_o.aw_valid = 1'b0;
        mst_rsp_o.aw_ready = 1'b0;
      end
    end
  end

  // Handshakes seen on the subordinate side
  assign aw_fire_o    = track & slv_req_o.aw_valid & slv_rsp_i.aw_ready;
  assign w_fire_o     = track & slv_req_o.w_valid & slv_rsp_i.w_ready;
  assign wlast_fire_o = w_fire_o & slv_req_o.w.last;
  assign b_fire_o     = track & slv_rsp_i.b_valid & slv_req_o.b_ready;

endmodule

// File: design/wguard_ctrl.sv
// ****************************
// Guard control
// Queue/timer commands, fault
// decision and sticky record
// ****************************
`timescale 1ns/1ps

module wguard_ctrl import wguard_pkg::*; #(
  parameter int unsigned MaxTxns   = 8,
  localparam int unsigned IdxWidth = $clog2(MaxTxns)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  guard_ena_i,
  input  logic                  fault_clr_i,
  input  logic                  aw_valid_i,
  input  logic                  aw_fire_i,
  input  logic                  wlast_fire_i,
  input  logic                  b_fire_i,
  input  axi_id_t               aw_id_i,
  input  axi_id_t               b_id_i,
  // Queue side
  output logic                  flush_o,
  output logic                  push_o,
  output logic                  w_done_o,
  output logic                  pop_o,
  input  logic                  w_head_valid_i,
  input  logic                  bid_hit_i,
  input  axi_id_t [MaxTxns-1:0] entry_ids_i,
  // Timer side
  output logic                  aw_wait_o,
  input  logic                  overrun_i,
  input  logic                  overrun_aw_i,
  input  fault_cause_e          overrun_cause_i,
  input  logic [IdxWidth-1:0]   overrun_idx_i,
  // Fault outputs
  output logic                  reset_req_o,
  output logic                  irq_o,
  output logic                  fault_active_o,
  output fault_rec_t            fault_o
);

  logic       track;
  logic       fault_set;
  fault_rec_t fault_d, fault_q;

  assign track = guard_ena_i & ~fault_active_o;

  // Entry bookkeeping follows the accepted handshakes
  assign push_o   = aw_fire_i;
  assign w_done_o = wlast_fire_i & w_head_valid_i;
  assign pop_o    = b_fire_i & bid_hit_i;
  assign flush_o  = fault_clr_i;

  // AW waits while offered and not taken, also when held off by a full queue
  assign aw_wait_o = track & aw_valid_i & ~aw_fire_i;

  always_comb begin
    fault_set = 1'b0;
    fault_d   = fault_q;
    if (track) begin
      if (overrun_i) begin
        fault_set     = 1'b1;
        fault_d.cause = overrun_cause_i;
        fault_d.id    = overrun_aw_i ? aw_id_i : entry_ids_i[overrun_idx_i];
      end else if (b_fire_i && !bid_hit_i) begin
        fault_set = 1'b1;
        fault_d   = '{cause: FaultBadBid, id: b_id_i};
      end
    end
  end

  // First cause is kept until software clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= '{cause: FaultNone, id: '0};
    end else if (fault_clr_i) begin
      fault_q <= '{cause: FaultNone, id: '0};
    end else if (fault_set) begin
      fault_q <= fault_d;
    end
  end

  assign fault_o        = fault_q;
  assign fault_active_o = (fault_q.cause != FaultNone);
  assign reset_req_o    = fault_active_o;
  assign irq_o          = fault_active_o;

  // A new fault shows on the reset request and interrupt one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fault_set && !fault_clr_i |=> reset_req_o && irq_o);

endmodule

// File: design/wguard_id_queue.sv
// ****************************
// Outstanding write tracker
// Head-tail table per ID, linked
// entry pool and W-order ring
// ****************************
`timescale 1ns/1ps

module wguard_id_queue import wguard_pkg::*; #(
  parameter int unsigned MaxTxns    = 8,
  parameter int unsigned MaxUniqIds = 4,
  localparam int unsigned IdxWidth  = $clog2(MaxTxns)
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         push_i,
  input  axi_id_t                      push_id_i,
  output logic [IdxWidth-1:0]          push_idx_o,
  input  logic                         w_done_i,
  output logic [IdxWidth-1:0]          w_head_idx_o,
  output logic                         w_head_valid_o,
  input  logic                         pop_i,
  input  axi_id_t                      pop_id_i,
  output logic [IdxWidth-1:0]          pop_idx_o,
  output logic                         bid_hit_o,
  output logic                         full_o,
  output axi_id_t [MaxTxns-1:0]        entry_ids_o
);

  localparam int unsigned HtWidth = (MaxUniqIds > 1) ? $clog2(MaxUniqIds) : 1;

  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [HtWidth-1:0]  ht_idx_t;

  typedef struct packed {
    axi_id_t id;
    idx_t    head;
    idx_t    tail;
    logic    valid;
  } ht_entry_t;

  typedef struct packed {
    axi_id_t id;
    idx_t    next;
    logic    done;
    logic    valid;
  } ld_entry_t;

  ht_entry_t [MaxUniqIds-1:0] ht_d, ht_q;
  ld_entry_t [MaxTxns-1:0]    ld_d, ld_q;
  logic      [MaxTxns-1:0]    ld_busy;
  logic      [MaxUniqIds-1:0] ht_busy;
  ht_idx_t                    bid_slot;

  // W-order ring, one slot per possible entry
  idx_t [MaxTxns-1:0]  w_ring_q;
  idx_t                w_wr_q, w_rd_q;
  logic [IdxWidth:0]   w_cnt_q;

  always_comb begin
    for (int i = 0; i < MaxTxns; i++) begin
      ld_busy[i]     = ld_q[i].valid;
      entry_ids_o[i] = ld_q[i].id;
    end
    for (int i = 0; i < MaxUniqIds; i++) begin
      ht_busy[i] = ht_q[i].valid;
    end
  end

  // Both the pool and the ID table must have room for any AW
  assign full_o         = (&ld_busy) | (&ht_busy);
  assign w_head_idx_o   = w_ring_q[w_rd_q];
  assign w_head_valid_o = (w_cnt_q != '0);

  // Head of the B ID is poppable once its burst has finished
  always_comb begin
    bid_hit_o = 1'b0;
    bid_slot  = '0;
    for (int i = 0; i < MaxUniqIds; i++) begin
      if (ht_q[i].valid && (ht_q[i].id == pop_id_i)) begin
        bid_slot  = ht_idx_t'(i);
        bid_hit_o = ld_q[ht_q[i].head].done;
      end
    end
  end

  assign pop_idx_o = ht_q[bid_slot].head;

  // Pop first, so the push sees the freed entry and table slot
  always_comb begin
    logic    match;
    ht_idx_t slot;

    ht_d       = ht_q;
    ld_d       = ld_q;
    push_idx_o = '0;
    match      = 1'b0;
    slot       = '0;

    if (w_done_i && w_head_valid_o) begin
      ld_d[w_head_idx_o].done = 1'b1;
    end

    if (pop_i && bid_hit_o) begin
      ld_d[pop_idx_o].valid = 1'b0;
      if (ht_q[bid_slot].tail == pop_idx_o) begin
        ht_d[bid_slot].valid = 1'b0;
      end else begin
        ht_d[bid_slot].head = ld_q[pop_idx_o].next;
      end
    end

    // Lowest free entry and table slot
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (!ld_d[i].valid) begin
        push_idx_o = idx_t'(i);
      end
    end
    for (int i = MaxUniqIds - 1; i >= 0; i--) begin
      if (!ht_d[i].valid) begin
        slot = ht_idx_t'(i);
      end
    end
    for (int i = 0; i < MaxUniqIds; i++) begin
      if (ht_d[i].valid && (ht_d[i].id == push_id_i)) begin
        match = 1'b1;
        slot  = ht_idx_t'(i);
      end
    end

    if (push_i) begin
      ld_d[push_idx_o] = '{id: push_id_i, next: '0, done: 1'b0, valid: 1'b1};
      if (match) begin
        ld_d[ht_d[slot].tail].next = push_idx_o;
        ht_d[slot].tail            = push_idx_o;
      end else begin
        ht_d[slot] = '{id: push_id_i, head: push_idx_o, tail: push_idx_o, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ht_q    <= '0;
      ld_q    <= '0;
      w_wr_q  <= '0;
      w_rd_q  <= '0;
      w_cnt_q <= '0;
    end else if (flush_i) begin
      ht_q    <= '0;
      ld_q    <= '0;
      w_wr_q  <= '0;
      w_rd_q  <= '0;
      w_cnt_q <= '0;
    end else begin
      ht_q <= ht_d;
      ld_q <= ld_d;
      if (push_i) begin
        w_wr_q <= w_wr_q + idx_t'(1);
      end
      if (w_done_i && w_head_valid_o) begin
        w_rd_q <= w_rd_q + idx_t'(1);
      end
      w_cnt_q <= w_cnt_q + (IdxWidth+1)'(push_i)
                 - (IdxWidth+1)'(w_done_i && w_head_valid_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      w_ring_q[w_wr_q] <= push_idx_o;
    end
  end

  // Back-pressure from the gate must keep AWs out of a full tracker
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> bid_hit_o);

endmodule

// File: design/wguard_phase_timer.sv
// ****************************
// Phase latency counters
// AW wait counter plus one data/B
// counter per tracked entry
// ****************************
`timescale 1ns/1ps

module wguard_phase_timer import wguard_pkg::*; #(
  parameter int unsigned MaxTxns   = 8,
  localparam int unsigned IdxWidth = $clog2(MaxTxns)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  budget_t             budget_i,
  input  logic                aw_wait_i,
  input  logic                start_i,
  input  logic [IdxWidth-1:0] start_idx_i,
  input  logic                wlast_i,
  input  logic [IdxWidth-1:0] wlast_idx_i,
  input  logic                stop_i,
  input  logic [IdxWidth-1:0] stop_idx_i,
  output logic                overrun_o,
  output logic                overrun_aw_o,
  output fault_cause_e        overrun_cause_o,
  output logic [IdxWidth-1:0] overrun_idx_o
);

  logic [MaxTxns-1:0] armed_q;
  logic [MaxTxns-1:0] b_phase_q;
  cnt_t [MaxTxns-1:0] cnt_q;
  cnt_t               aw_cnt_q;

  // Lowest overrunning entry wins, AW wait beats all entries
  always_comb begin
    overrun_o       = 1'b0;
    overrun_aw_o    = 1'b0;
    overrun_cause_o = FaultNone;
    overrun_idx_o   = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (armed_q[i] &&
          (cnt_q[i] == (b_phase_q[i] ? budget_i.b_wait : budget_i.w_complete))) begin
        overrun_o       = 1'b1;
        overrun_idx_o   = IdxWidth'(i);
        overrun_cause_o = b_phase_q[i] ? FaultTimeout : FaultWTimeout;
      end
    end
    if (aw_wait_i && (aw_cnt_q == budget_i.aw_accept)) begin
      overrun_o       = 1'b1;
      overrun_aw_o    = 1'b1;
      overrun_cause_o = FaultTimeout;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q   <= '0;
      b_phase_q <= '0;
      cnt_q     <= '0;
      aw_cnt_q  <= '0;
    end else if (flush_i) begin
      armed_q   <= '0;
      b_phase_q <= '0;
      cnt_q     <= '0;
      aw_cnt_q  <= '0;
    end else begin
      aw_cnt_q <= aw_wait_i ? aw_cnt_q + cnt_t'(1) : '0;
      for (int i = 0; i < MaxTxns; i++) begin
        // A freed entry may be restarted in the cycle it stops
        if (start_i && (start_idx_i == IdxWidth'(i))) begin
          armed_q[i]   <= 1'b1;
          b_phase_q[i] <= 1'b0;
          cnt_q[i]     <= '0;
        end else if (wlast_i && (wlast_idx_i == IdxWidth'(i))) begin
          b_phase_q[i] <= 1'b1;
          cnt_q[i]     <= '0;
        end else if (stop_i && (stop_idx_i == IdxWidth'(i))) begin
          armed_q[i] <= 1'b0;
        end else if (armed_q[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !armed_q[start_idx_i] || (stop_i && (stop_idx_i == start_idx_i)));

endmodule

// File: design/wguard_pkg.sv
// ****************************
// Write guard shared definitions
// Width constants, channel structs,
// latency budgets and fault record
// ****************************
package wguard_pkg;

  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 16;
  localparam int unsigned CntWidth  = 8;

  typedef logic [CntWidth-1:0] cnt_t;
  typedef logic [IdWidth-1:0]  axi_id_t;

  typedef struct packed {
    axi_id_t              id;
    logic [AddrWidth-1:0] addr;
  } aw_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 last;
  } w_chan_t;

  typedef struct packed {
    axi_id_t    id;
    logic [1:0] resp;
  } b_chan_t;

  // Manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
  } wr_req_t;

  // Subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
  } wr_rsp_t;

  // Cycle budgets for the three write phases
  typedef struct packed {
    cnt_t aw_accept;
    cnt_t w_complete;
    cnt_t b_wait;
  } budget_t;

  typedef enum logic [1:0] {
    FaultNone,
    FaultTimeout,
    FaultBadBid,
    FaultWTimeout
  } fault_cause_e;

  typedef struct packed {
    fault_cause_e cause;
    axi_id_t      id;
  } fault_rec_t;

  // SLVERR code returned for dropped bursts
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: design/wguard_top.sv
// ****************************
// Write guard top level
// Gate, control, ID queue and
// phase timer
// ****************************
`timescale 1ns/1ps

module wguard_top import wguard_pkg::*; #(
  parameter int unsigned MaxTxns    = 8,
  parameter int unsigned MaxUniqIds = 4
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       guard_ena_i,
  input  logic       fault_clr_i,
  input  wr_req_t    mst_req_i,
  output wr_rsp_t    mst_rsp_o,
  output wr_req_t    slv_req_o,
  input  wr_rsp_t    slv_rsp_i,
  input  budget_t    budget_i,
  output logic       reset_req_o,
  output logic       irq_o,
  output fault_rec_t fault_o
);

  localparam int unsigned IdxWidth = $clog2(MaxTxns);

  logic                  aw_fire, wlast_fire, b_fire;
  logic                  fault_active, flush;
  logic                  push, w_done, pop, full, bid_hit, w_head_valid;
  logic [IdxWidth-1:0]   push_idx, w_head_idx, pop_idx, overrun_idx;
  axi_id_t [MaxTxns-1:0] entry_ids;
  logic                  aw_wait, overrun, overrun_aw;
  fault_cause_e          overrun_cause;

  wguard_chan_gate i_gate (
    .guard_ena_i    (guard_ena_i),
    .fault_active_i (fault_active),
    .aw_block_i     (full),
    .mst_req_i      (mst_req_i),
    .mst_rsp_o      (mst_rsp_o),
    .slv_req_o      (slv_req_o),
    .slv_rsp_i      (slv_rsp_i),
    .aw_fire_o      (aw_fire),
    .w_fire_o       (),
    .wlast_fire_o   (wlast_fire),
    .b_fire_o       (b_fire)
  );

  wguard_ctrl #(
    .MaxTxns (MaxTxns)
  ) i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .guard_ena_i     (guard_ena_i),
    .fault_clr_i     (fault_clr_i),
    .aw_valid_i      (mst_req_i.aw_valid),
    .aw_fire_i       (aw_fire),
    .wlast_fire_i    (wlast_fire),
    .b_fire_i        (b_fire),
    .aw_id_i         (mst_req_i.aw.id),
    .b_id_i          (slv_rsp_i.b.id),
    .flush_o         (flush),
    .push_o          (push),
    .w_done_o        (w_done),
    .pop_o           (pop),
    .w_head_valid_i  (w_head_valid),
    .bid_hit_i       (bid_hit),
    .entry_ids_i     (entry_ids),
    .aw_wait_o       (aw_wait),
    .overrun_i       (overrun),
    .overrun_aw_i    (overrun_aw),
    .overrun_cause_i (overrun_cause),
    .overrun_idx_i   (overrun_idx),
    .reset_req_o     (reset_req_o),
    .irq_o           (irq_o),
    .fault_active_o  (fault_active),
    .fault_o         (fault_o)
  );

  wguard_id_queue #(
    .MaxTxns    (MaxTxns),
    .MaxUniqIds (MaxUniqIds)
  ) i_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush),
    .push_i         (push),
    .push_id_i      (slv_req_o.aw.id),
    .push_idx_o     (push_idx),
    .w_done_i       (w_done),
    .w_head_idx_o   (w_head_idx),
    .w_head_valid_o (w_head_valid),
    .pop_i          (pop),
    .pop_id_i       (slv_rsp_i.b.id),
    .pop_idx_o      (pop_idx),
    .bid_hit_o      (bid_hit),
    .full_o         (full),
    .entry_ids_o    (entry_ids)
  );

  wguard_phase_timer #(
    .MaxTxns (MaxTxns)
  ) i_timer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush),
    .budget_i        (budget_i),
    .aw_wait_i       (aw_wait),
    .start_i         (push),
    .start_idx_i     (push_idx),
    .wlast_i         (w_done),
    .wlast_idx_i     (w_head_idx),
    .stop_i          (pop),
    .stop_idx_i      (pop_idx),
    .overrun_o       (overrun),
    .overrun_aw_o    (overrun_aw),
    .overrun_cause_o (overrun_cause),
    .overrun_idx_o   (overrun_idx)
  );

endmodule

// File: dv/tb_wguard.sv
// ****************************
// Write guard testbench
// Clock, reset, subordinate model,
// stimulus table, checks, timeout
// ****************************
`timescale 1ns/1ps

module tb_wguard import wguard_pkg::*; ();

  localparam int NumRows    = 9;
  localparam int RowCycles  = 64;
  localparam int CycleLimit = NumRows * RowCycles + 16;

  typedef struct packed {
    logic         ena;
    axi_id_t      id;
    int           beats;
    int           aw_dly;
    int           w_dly;
    int           b_dly;
    logic         bid_ovr;
    axi_id_t      bid;
    budget_t      budget;
    fault_cause_e exp_cause;
    axi_id_t      exp_id;
    logic         exp_rst;
  } row_t;

  logic       clk_i;
  logic       rst_ni;
  logic       guard_ena_i;
  logic       fault_clr_i;
  wr_req_t    mst_req;
  wr_rsp_t    mst_rsp;
  wr_req_t    slv_req;
  wr_rsp_t    slv_rsp;
  budget_t    budget;
  logic       reset_req;
  logic       irq;
  fault_rec_t fault;

  row_t        rows [NumRows];
  logic [31:0] rng_q = 32'hdc7c_afc1;
  int          cycles;

  wguard_top #(
    .MaxTxns    (8),
    .MaxUniqIds (4)
  ) dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .guard_ena_i (guard_ena_i),
    .fault_clr_i (fault_clr_i),
    .mst_req_i   (mst_req),
    .mst_rsp_o   (mst_rsp),
    .slv_req_o   (slv_req),
    .slv_rsp_i   (slv_rsp),
    .budget_i    (budget),
    .reset_req_o (reset_req),
    .irq_o       (irq),
    .fault_o     (fault)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  function automatic budget_t make_budget(input int aw, input int w, input int b);
    return '{aw_accept: cnt_t'(aw), w_complete: cnt_t'(w), b_wait: cnt_t'(b)};
  endfunction

  task automatic load_table();
    // ena, id, beats, aw/w/b delay, bid override, budgets, cause, fault id, reset req
    rows[0] = '{1'b1, 4'd1, 4, 1, 0, 2, 1'b0, 4'd0, make_budget(20, 20, 20),
                FaultNone, 4'd0, 1'b0};
    rows[1] = '{1'b1, 4'd5, 2, 0, 2, 0, 1'b0, 4'd0, make_budget(20, 20, 20),
                FaultNone, 4'd0, 1'b0};
    // B arrives long after the last beat
    rows[2] = '{1'b1, 4'd2, 3, 0, 0, 10, 1'b0, 4'd0, make_budget(20, 20, 5),
                FaultTimeout, 4'd2, 1'b1};
    rows[3] = '{1'b1, 4'd7, 1, 3, 1, 1, 1'b0, 4'd0, make_budget(20, 20, 20),
                FaultNone, 4'd0, 1'b0};
    // Burst too long for its data budget
    rows[4] = '{1'b1, 4'd4, 8, 0, 0, 1, 1'b0, 4'd0, make_budget(20, 4, 20),
                FaultWTimeout, 4'd4, 1'b1};
    rows[5] = '{1'b1, 4'd3, 2, 0, 0, 1, 1'b1, 4'd9, make_budget(20, 20, 20),
                FaultBadBid, 4'd9, 1'b1};
    // Subordinate slow to take the address
    rows[6] = '{1'b1, 4'd6, 2, 12, 0, 1, 1'b0, 4'd0, make_budget(6, 20, 20),
                FaultTimeout, 4'd6, 1'b1};
    // Bypass, every phase over budget
    rows[7] = '{1'b0, 4'd2, 8, 12, 3, 15, 1'b0, 4'd0, make_budget(4, 4, 4),
                FaultNone, 4'd0, 1'b0};
    rows[8] = '{1'b1, 4'd10, 5, 1, 1, 3, 1'b0, 4'd0, make_budget(20, 20, 20),
                FaultNone, 4'd0, 1'b0};
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Sampled at the falling edge, between drive and capture
  task automatic watch_outputs(input row_t r);
    if (!r.ena) begin
      check_val("slv_req_o", 64'(slv_req), 64'(mst_req));
      check_val("mst_rsp_o", 64'(mst_rsp), 64'(slv_rsp));
    end
    if (r.exp_cause == FaultNone) begin
      check_val("reset_req_o", 64'(reset_req), 64'(1'b0));
      check_val("irq_o", 64'(irq), 64'(1'b0));
    end
  endtask

  task automatic run_row(input row_t r);
    int          n;
    logic        done;
    logic        got_last;
    logic        got_b;
    b_chan_t     b_seen;
    b_chan_t     b_exp;
    fault_rec_t  rec_exp;
    logic [31:0] rnd;

    guard_ena_i = r.ena;
    budget      = r.budget;
    got_last    = 1'b0;
    got_b       = 1'b0;
    b_seen      = '0;

    // Address phase, subordinate ready after aw_dly cycles
    rnd              = next_rand();
    mst_req.aw       = '{id: r.id, addr: rnd[15:0]};
    mst_req.aw_valid = 1'b1;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      slv_rsp.aw_ready = (n >= r.aw_dly);
      @(negedge clk_i);
      watch_outputs(r);
      done = mst_rsp.aw_ready;
      next_cycle();
      n++;
    end
    mst_req.aw_valid = 1'b0;
    slv_rsp.aw_ready = 1'b0;

    // Data phase, ready held off at the start of the burst
    n = 0;
    for (int beat = 0; beat < r.beats; beat++) begin
      rnd             = next_rand();
      mst_req.w       = '{data: rnd[31:16], last: (beat == r.beats - 1)};
      mst_req.w_valid = 1'b1;
      done            = 1'b0;
      while (!done) begin
        slv_rsp.w_ready = (n >= r.w_dly);
        @(negedge clk_i);
        watch_outputs(r);
        if (slv_req.w_valid && slv_rsp.w_ready && slv_req.w.last) begin
          got_last = 1'b1;
        end
        done = mst_rsp.w_ready;
        next_cycle();
        n++;
      end
    end
    mst_req.w_valid = 1'b0;
    slv_rsp.w_ready = 1'b0;

    // Subordinate answers only a burst it saw complete
    if (got_last) begin
      n         = 0;
      done      = 1'b0;
      slv_rsp.b = '{id: r.bid_ovr ? r.bid : r.id, resp: 2'b00};
      while (!done) begin
        slv_rsp.b_valid = (n >= r.b_dly);
        @(negedge clk_i);
        watch_outputs(r);
        if (mst_rsp.b_valid) begin
          got_b  = 1'b1;
          b_seen = mst_rsp.b;
        end
        done = slv_rsp.b_valid && slv_req.b_ready;
        next_cycle();
        n++;
      end
      slv_rsp.b_valid = 1'b0;
    end

    if (r.exp_cause == FaultNone) begin
      b_exp = '{id: r.id, resp: 2'b00};
      check_val("mst_rsp_o.b_valid", 64'(got_b), 64'(1'b1));
      check_val("mst_rsp_o.b", 64'(b_seen), 64'(b_exp));
    end

    repeat (2) begin
      @(negedge clk_i);
      watch_outputs(r);
    end
    rec_exp = '{cause: r.exp_cause, id: r.exp_id};
    check_val("fault_o", 64'(fault), 64'(rec_exp));
    check_val("reset_req_o", 64'(reset_req), 64'(r.exp_rst));
    check_val("irq_o", 64'(irq), 64'(r.exp_rst));
    next_cycle();
  endtask

  // Isolated guard must still accept everything and answer with SLVERR
  task automatic drain_probe();
    logic [31:0] rnd;
    rnd              = next_rand();
    mst_req.aw       = '{id: rnd[3:0], addr: rnd[19:4]};
    mst_req.aw_valid = 1'b1;
    mst_req.w        = '{data: rnd[31:16], last: 1'b1};
    mst_req.w_valid  = 1'b1;
    @(negedge clk_i);
    check_val("mst_rsp_o.aw_ready", 64'(mst_rsp.aw_ready), 64'(1'b1));
    check_val("mst_rsp_o.w_ready", 64'(mst_rsp.w_ready), 64'(1'b1));
    check_val("mst_rsp_o.b_valid", 64'(mst_rsp.b_valid), 64'(1'b1));
    check_val("mst_rsp_o.b.resp", 64'(mst_rsp.b.resp), 64'(resp_slverr));
    check_val("slv_req_o.aw_valid", 64'(slv_req.aw_valid), 64'(1'b0));
    check_val("slv_req_o.w_valid", 64'(slv_req.w_valid), 64'(1'b0));
    next_cycle();
    mst_req.aw_valid = 1'b0;
    mst_req.w_valid  = 1'b0;
  endtask

  task automatic clear_fault();
    fault_clr_i = 1'b1;
    next_cycle();
    fault_clr_i = 1'b0;
    @(negedge clk_i);
    check_val("fault_o", 64'(fault), 64'(fault_rec_t'('0)));
    check_val("reset_req_o", 64'(reset_req), 64'(1'b0));
    next_cycle();
  endtask

  initial begin
    rst_ni      = 1'b0;
    guard_ena_i = 1'b0;
    fault_clr_i = 1'b0;
    mst_req     = '0;
    slv_rsp     = '0;
    budget      = '0;
    load_table();
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    mst_req.b_ready = 1'b1;
    next_cycle();
    for (int i = 0; i < NumRows; i++) begin
      run_row(rows[i]);
      if (rows[i].exp_rst) begin
        drain_probe();
      end
      clear_fault();
    end
    $display("TEST OK");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the write sequence did not finish", cycles);
    $display("TEST FAILED");
    $fatal(1, "cycle limit reached");
  end

endmodule

// File: files.f
design/wguard_pkg.sv
design/wguard_id_queue.sv
design/wguard_phase_timer.sv
design/wguard_ctrl.sv
design/wguard_chan_gate.sv
design/wguard_top.sv
dv/tb_wguard.sv
